//--- src/soc_pkg.sv
package soc_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  localparam int unsigned WordOffset = $clog2(StrbWidth);

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam logic [AddrWidth-1:0] RomBase    = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength  = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] GpioBase   = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] GpioLength = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] DramBase   = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] DramLength = 32'h0000_2000;

  // Memory depths and the index widths derived from them
  localparam int unsigned RomWords     = 8;
  localparam int unsigned SramWords    = 1024;
  localparam int unsigned RomIdxWidth  = $clog2(RomWords);
  localparam int unsigned SramIdxWidth = $clog2(SramWords);

  // Boot code, first instruction in the low half of each word
  localparam logic [0:RomWords-1][DataWidth-1:0] BootImage = '{
    64'h00000597_f1402573,  // csrr a0, mhartid ; auipc a1, 0
    64'h800002b7_02058593,  // addi a1, a1, 32 ; lui t0, 0x80000
    64'h10500073_00028067,  // jr t0 ; wfi
    64'h00000013_ffdff06f,  // j wfi ; nop
    64'h00000000_edfe0dd0,
    64'h00000000_00000038,
    64'h00000000_00000048,
    64'h00000000_00000011
  };

  // Debug request hold-off after power-on
  localparam int unsigned DmiDelCycles = 500;
  localparam int unsigned DmiCntWidth  = $clog2(DmiDelCycles + 1);

  // ----------------------------------------
  // Bus types
  // ----------------------------------------
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    SelRom  = 2'd0,
    SelSram = 2'd1,
    SelErr  = 2'd2
  } slave_sel_e;

endpackage

//--- src/soc_rstgen.sv
`timescale 1ns/1ps

module soc_rstgen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic periph_rst_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  // Either source asserts immediately
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Release is synchronized to clk_i over two flops
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign periph_rst_no = sync_q[1];

  // The fabric must stay in reset for the whole ndmreset pulse
  a_ndmreset_holds: assert property (
    @(posedge clk_i) ndmreset_i |-> !periph_rst_no
  ) else $error("peripheral reset released during ndmreset");

endmodule

//--- src/debug_req_gate.sv
`timescale 1ns/1ps

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);
  import soc_pkg::*;

  logic [DmiCntWidth-1:0] cnt_q;
  logic                   holdoff;

  // ----------------------------------------
  // Power-on hold-off counter
  // ----------------------------------------
  // Gives the boot code time to run before the first halt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= DmiCntWidth'(DmiDelCycles);
    end else if (holdoff) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign holdoff = (cnt_q != '0);

  // ----------------------------------------
  // Request gating
  // ----------------------------------------
  assign debug_req_o = !holdoff && debug_enable_i && debug_req_i;

  // No halt request may reach the core during the hold-off window
  a_no_req_in_holdoff: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cnt_q != '0) |-> !debug_req_o
  ) else $error("debug request leaked during hold-off");

endmodule

//--- src/bus_addr_decoder.sv
`timescale 1ns/1ps

module bus_addr_decoder (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_valid_i,
  input  soc_pkg::bus_req_t                req_i,
  output logic                             rsp_valid_o,
  output soc_pkg::bus_rsp_t                rsp_o,
  output logic                             rom_req_o,
  output logic [soc_pkg::RomIdxWidth-1:0]  rom_idx_o,
  input  logic [soc_pkg::DataWidth-1:0]    rom_rdata_i,
  output logic                             sram_req_o,
  output logic                             sram_we_o,
  output logic [soc_pkg::SramIdxWidth-1:0] sram_idx_o,
  output logic [soc_pkg::StrbWidth-1:0]    sram_be_o,
  output logic [soc_pkg::DataWidth-1:0]    sram_wdata_o,
  input  logic [soc_pkg::DataWidth-1:0]    sram_rdata_i
);
  import soc_pkg::*;

  logic [AddrWidth-1:0] rom_off;
  logic [AddrWidth-1:0] dram_off;
  logic                 rom_hit;
  logic                 dram_hit;
  logic                 req_taken;
  slave_sel_e           sel_d;
  slave_sel_e           sel_q;
  logic                 valid_q;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign rom_off  = req_i.addr - RomBase;
  assign dram_off = req_i.addr - DramBase;

  // Only the first RomWords words of the ROM window are backed
  assign rom_hit  = (req_i.addr >= RomBase) && (rom_off < RomLength)
                    && (rom_off[AddrWidth-1:WordOffset] < RomWords);
  assign dram_hit = (req_i.addr >= DramBase) && (dram_off < DramLength);

  always_comb begin
    // GPIO has no slave, answered from the error path
    sel_d = SelErr;
    if (rom_hit && !req_i.we) begin
      sel_d = SelRom;
    end else if (dram_hit) begin
      sel_d = SelSram;
    end
  end

  // Nothing is accepted while the fabric is held in reset
  assign req_taken = req_valid_i && rst_ni;

  // ----------------------------------------
  // Slave strobes
  // ----------------------------------------
  assign rom_req_o    = req_taken && (sel_d == SelRom);
  assign rom_idx_o    = rom_off[WordOffset +: RomIdxWidth];

  assign sram_req_o   = req_taken && (sel_d == SelSram);
  assign sram_we_o    = req_i.we;
  assign sram_idx_o   = dram_off[WordOffset +: SramIdxWidth];
  assign sram_be_o    = req_i.be;
  assign sram_wdata_o = req_i.wdata;

  // ----------------------------------------
  // Response path
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      sel_q   <= SelErr;
    end else begin
      valid_q <= req_taken;
      if (req_taken) begin
        sel_q <= sel_d;
      end
    end
  end

  assign rsp_valid_o = valid_q;

  // Error responses carry zero data
  always_comb begin
    rsp_o = '0;
    unique case (sel_q)
      SelRom:  rsp_o.rdata = rom_rdata_i;
      SelSram: rsp_o.rdata = sram_rdata_i;
      default: rsp_o.err   = 1'b1;
    endcase
  end

  // Every response answers a request from the cycle before
  a_rsp_follows_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> $past(req_valid_i)
  ) else $error("response without a request one cycle earlier");

endmodule

//--- src/boot_rom.sv
`timescale 1ns/1ps

module boot_rom (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_i,
  input  logic [soc_pkg::RomIdxWidth-1:0] idx_i,
  output logic [soc_pkg::DataWidth-1:0]   rdata_o
);
  import soc_pkg::*;

  logic [DataWidth-1:0] rdata_q;

  // Registered read, data held between strobes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i) begin
      rdata_q <= BootImage[idx_i];
    end
  end

  assign rdata_o = rdata_q;

  // Decoder must never strobe past the end of the image
  a_idx_in_image: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (int'(idx_i) < RomWords)
  ) else $error("boot ROM index %0d out of range", idx_i);

endmodule

//--- src/main_sram.sv
`timescale 1ns/1ps

module main_sram (
  input  logic                             clk_i,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [soc_pkg::SramIdxWidth-1:0] idx_i,
  input  logic [soc_pkg::StrbWidth-1:0]    be_i,
  input  logic [soc_pkg::DataWidth-1:0]    wdata_i,
  output logic [soc_pkg::DataWidth-1:0]    rdata_o
);
  import soc_pkg::*;

  logic [DataWidth-1:0] mem_q [SramWords];
  logic [DataWidth-1:0] rdata_q;

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (be_i[b]) begin
          mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read port, last word held on writes and idle cycles
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[idx_i];
    end
  end

  assign rdata_o = rdata_q;

  // A write with no byte enables means the master built a bad request
  a_write_has_be: assert property (
    @(posedge clk_i) (req_i && we_i) |-> (be_i != '0)
  ) else $error("SRAM write with all byte enables clear");

endmodule

//--- src/soc_harness_top.sv
`timescale 1ns/1ps

module soc_harness_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              ndmreset_i,
  input  logic              debug_req_i,
  input  logic              debug_enable_i,
  output logic              debug_req_o,
  input  logic              req_valid_i,
  input  soc_pkg::bus_req_t req_i,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t rsp_o
);
  import soc_pkg::*;

  logic                    periph_rst_n;

  logic                    rom_req;
  logic [RomIdxWidth-1:0]  rom_idx;
  logic [DataWidth-1:0]    rom_rdata;

  logic                    sram_req;
  logic                    sram_we;
  logic [SramIdxWidth-1:0] sram_idx;
  logic [StrbWidth-1:0]    sram_be;
  logic [DataWidth-1:0]    sram_wdata;
  logic [DataWidth-1:0]    sram_rdata;

  // ----------------------------------------
  // Reset and debug glue
  // ----------------------------------------
  soc_rstgen i_rstgen (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .ndmreset_i    ( ndmreset_i   ),
    .periph_rst_no ( periph_rst_n )
  );

  // Hold-off only restarts on power-on reset
  debug_req_gate i_debug_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

  // ----------------------------------------
  // Fabric and memories
  // ----------------------------------------
  bus_addr_decoder i_decoder (
    .clk_i        ( clk_i        ),
    .rst_ni       ( periph_rst_n ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_o        ( rsp_o        ),
    .rom_req_o    ( rom_req      ),
    .rom_idx_o    ( rom_idx      ),
    .rom_rdata_i  ( rom_rdata    ),
    .sram_req_o   ( sram_req     ),
    .sram_we_o    ( sram_we      ),
    .sram_idx_o   ( sram_idx     ),
    .sram_be_o    ( sram_be      ),
    .sram_wdata_o ( sram_wdata   ),
    .sram_rdata_i ( sram_rdata   )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i        ),
    .rst_ni  ( periph_rst_n ),
    .req_i   ( rom_req      ),
    .idx_i   ( rom_idx      ),
    .rdata_o ( rom_rdata    )
  );

  main_sram i_main_sram (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .idx_i   ( sram_idx   ),
    .be_i    ( sram_be    ),
    .wdata_i ( sram_wdata ),
    .rdata_o ( sram_rdata )
  );

endmodule

//--- dv/tb_soc_harness.sv
`timescale 1ns/1ps

module tb_soc_harness;
  import soc_pkg::*;

  typedef struct packed {
    logic     chk;
    bus_rsp_t rsp;
  } exp_t;

  localparam int NumWords = 16;

  logic        clk_i;
  logic        rst_ni;
  logic        ndmreset_i;
  logic        debug_req_i;
  logic        debug_enable_i;
  logic        debug_req_o;
  logic        req_valid_i;
  bus_req_t    req_i;
  logic        rsp_valid_o;
  bus_rsp_t    rsp_o;

  logic [15:0] lfsr_q;
  logic [7:0]  sram_model [SramWords*StrbWidth];
  int          used_idx [NumWords];
  bus_req_t    req_q [$];
  int          tests_run;
  int          tests_failed;
  int          total_errs;

  soc_harness_top dut_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ndmreset_i     ( ndmreset_i     ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    ),
    .req_valid_i    ( req_valid_i    ),
    .req_i          ( req_i          ),
    .rsp_valid_o    ( rsp_valid_o    ),
    .rsp_o          ( rsp_o          )
  );

  always #50 clk_i = ~clk_i;

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic bus_req_t make_req(input logic [AddrWidth-1:0] addr, input logic we,
                                        input logic [StrbWidth-1:0] be,
                                        input logic [DataWidth-1:0] wdata);
    bus_req_t r;
    r.addr  = addr;
    r.we    = we;
    r.be    = be;
    r.wdata = wdata;
    return r;
  endfunction

  function automatic logic [AddrWidth-1:0] sram_addr(input int idx);
    return DramBase + AddrWidth'(idx * StrbWidth);
  endfunction

  // Expected response from the address map, updates the byte model on writes
  function automatic exp_t predict(input bus_req_t r);
    exp_t        e;
    int unsigned idx;
    e     = '0;
    e.chk = 1'b1;
    if (!r.we && r.addr >= RomBase && r.addr < RomBase + RomWords * StrbWidth) begin
      e.rsp.rdata = BootImage[int'((r.addr - RomBase) >> WordOffset)];
    end else if (r.addr >= DramBase && r.addr < DramBase + DramLength) begin
      idx   = (r.addr - DramBase) >> WordOffset;
      e.chk = !r.we;
      for (int b = 0; b < StrbWidth; b++) begin
        if (r.we && r.be[b]) begin
          sram_model[idx*StrbWidth + b] = r.wdata[b*8 +: 8];
        end else if (!r.we) begin
          e.rsp.rdata[b*8 +: 8] = sram_model[idx*StrbWidth + b];
        end
      end
    end else begin
      e.rsp.err = 1'b1;
    end
    return e;
  endfunction

  task automatic check_rsp(input exp_t e, inout int errs);
    if (!rsp_valid_o) begin
      $display("no response one cycle after the request at %0d ns", $time);
      errs++;
    end else if (rsp_o.err != e.rsp.err) begin
      $display("[ERROR] %0d ns: err flag %0b, expected %0b", $time, rsp_o.err, e.rsp.err);
      errs++;
    end else if (e.chk && rsp_o.rdata != e.rsp.rdata) begin
      $display("[ERROR] %0d ns: rdata %h, expected %h", $time, rsp_o.rdata, e.rsp.rdata);
      errs++;
    end
  endtask

  // Issues the queued requests back to back, one response check per cycle
  task automatic run_queue(inout int errs);
    exp_t exp_q [$];
    int   n;
    n = req_q.size();
    for (int i = 0; i <= n; i++) begin
      @(posedge clk_i);
      if (i < n) begin
        req_valid_i <= 1'b1;
        req_i       <= req_q[i];
        exp_q.push_back(predict(req_q[i]));
      end else begin
        req_valid_i <= 1'b0;
        req_i       <= '0;
      end
      @(negedge clk_i);
      if (i == 0) begin
        if (rsp_valid_o) begin
          $display("response at %0d ns with no request before it", $time);
          errs++;
        end
      end else begin
        check_rsp(exp_q.pop_front(), errs);
      end
    end
    @(negedge clk_i);
    if (rsp_valid_o) begin
      $display("stray response at %0d ns after the last request", $time);
      errs++;
    end
    req_q.delete();
  endtask

  task automatic report_test(input string name, input int errs);
    tests_run++;
    total_errs += errs;
    if (errs != 0) begin
      tests_failed++;
      $display("%s: %0d errors", name, errs);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_debug_gate();
    int cycles;
    int errs;
    cycles = 0;
    errs   = 0;
    @(negedge clk_i);
    while (!debug_req_o && cycles < DmiDelCycles + 20) begin
      cycles++;
      @(negedge clk_i);
    end
    if (!debug_req_o) begin
      $display("timeout, debug_req_o never rose after %0d cycles", cycles);
      errs++;
    end else if (cycles != DmiDelCycles) begin
      $display("[ERROR] %0d ns: hold-off %0d cycles, expected %0d", $time, cycles,
               DmiDelCycles);
      errs++;
    end
    @(posedge clk_i);
    debug_enable_i <= 1'b0;
    @(negedge clk_i);
    if (debug_req_o) begin
      $display("[ERROR] %0d ns: debug_req_o high with enable low", $time);
      errs++;
    end
    @(posedge clk_i);
    debug_enable_i <= 1'b1;
    @(negedge clk_i);
    if (!debug_req_o) begin
      $display("[ERROR] %0d ns: debug_req_o low with enable back high", $time);
      errs++;
    end
    report_test("debug_gate", errs);
  endtask

  task automatic test_rom_reads();
    int errs;
    errs = 0;
    for (int i = 0; i < RomWords; i++) begin
      req_q.push_back(make_req(RomBase + AddrWidth'(i * StrbWidth), 1'b0, '0, '0));
    end
    for (int i = int'(RomWords) - 1; i >= 0; i--) begin
      req_q.push_back(make_req(RomBase + AddrWidth'(i * StrbWidth), 1'b0, '0, '0));
    end
    run_queue(errs);
    report_test("rom_reads", errs);
  endtask

  task automatic test_sram_rw();
    int                   errs;
    logic [StrbWidth-1:0] be;
    errs = 0;
    // Full words first so that every byte read later is known
    for (int i = 0; i < NumWords; i++) begin
      used_idx[i] = int'(rand_bits(SramIdxWidth));
      req_q.push_back(make_req(sram_addr(used_idx[i]), 1'b1, '1, rand_bits(DataWidth)));
    end
    for (int i = 0; i < NumWords; i++) begin
      be = StrbWidth'(rand_bits(StrbWidth));
      if (be == '0) begin
        be = StrbWidth'(1);
      end
      req_q.push_back(make_req(sram_addr(used_idx[i]), 1'b1, be, rand_bits(DataWidth)));
    end
    for (int i = 0; i < NumWords; i++) begin
      req_q.push_back(make_req(sram_addr(used_idx[i]), 1'b0, '0, '0));
    end
    run_queue(errs);
    report_test("sram_rw", errs);
  endtask

  task automatic test_error_rsp();
    int errs;
    errs = 0;
    req_q.push_back(make_req(RomBase, 1'b1, '1, rand_bits(DataWidth)));
    req_q.push_back(make_req(GpioBase, 1'b0, '0, '0));
    req_q.push_back(make_req(GpioBase + 32'h8, 1'b1, '1, rand_bits(DataWidth)));
    req_q.push_back(make_req(32'h2000_0000, 1'b0, '0, '0));
    // Inside the ROM window but past the image
    req_q.push_back(make_req(RomBase + RomWords * StrbWidth, 1'b0, '0, '0));
    req_q.push_back(make_req(DramBase + DramLength, 1'b0, '0, '0));
    run_queue(errs);
    report_test("error_rsp", errs);
  endtask

  task automatic test_ndmreset();
    int   errs;
    int   cycles;
    logic got;
    errs   = 0;
    cycles = 0;
    got    = 1'b0;
    @(posedge clk_i);
    ndmreset_i <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_i);
      req_valid_i <= 1'b1;
      // Writes over live SRAM words, all of them must be dropped
      req_i       <= make_req(sram_addr(used_idx[i]), 1'b1, '1, rand_bits(DataWidth));
      @(negedge clk_i);
      if (rsp_valid_o) begin
        $display("response at %0d ns while ndmreset was high", $time);
        errs++;
      end
      if (!debug_req_o) begin
        $display("[ERROR] %0d ns: debug hold-off restarted by ndmreset", $time);
        errs++;
      end
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    ndmreset_i  <= 1'b0;
    // Poll with ROM reads until the synchronizer lets the fabric out
    while (!got && cycles < 10) begin
      @(posedge clk_i);
      req_valid_i <= 1'b1;
      req_i       <= make_req(RomBase, 1'b0, '0, '0);
      @(negedge clk_i);
      got = rsp_valid_o;
      cycles++;
    end
    if (!got) begin
      $display("timeout, no response within %0d cycles after ndmreset", cycles);
      errs++;
    end else if (rsp_o.err || rsp_o.rdata != BootImage[0]) begin
      $display("[ERROR] %0d ns: ROM word 0 read %h after ndmreset", $time, rsp_o.rdata);
      errs++;
    end else if (cycles != 3) begin
      // Two synchronizer edges, then one cycle for the response
      $display("[ERROR] %0d ns: first response %0d cycles after release, expected 3",
               $time, cycles);
      errs++;
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    @(negedge clk_i);
    for (int i = 0; i < NumWords; i++) begin
      req_q.push_back(make_req(sram_addr(used_idx[i]), 1'b0, '0, '0));
    end
    run_queue(errs);
    if (!debug_req_o) begin
      $display("[ERROR] %0d ns: debug_req_o low after the ndmreset pulse", $time);
      errs++;
    end
    report_test("ndmreset", errs);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    ndmreset_i     = 1'b0;
    debug_req_i    = 1'b1;
    debug_enable_i = 1'b1;
    req_valid_i    = 1'b0;
    req_i          = '0;
    lfsr_q         = 16'd47;
    tests_run      = 0;
    tests_failed   = 0;
    total_errs     = 0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Hold-off is measured from the reset release edge, so it runs first
    test_debug_gate();
    test_rom_reads();
    test_sram_rw();
    test_error_rsp();
    test_ndmreset();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- soc_harness_top.f
src/soc_pkg.sv
src/soc_rstgen.sv
src/debug_req_gate.sv
src/bus_addr_decoder.sv
src/boot_rom.sv
src/main_sram.sv
src/soc_harness_top.sv
dv/tb_soc_harness.sv

//--- Makefile
# Verilator flow for the SoC harness

VERILATOR ?= verilator
TOP       ?= tb_soc_harness
RTL_TOP   ?= soc_harness_top
FILELIST  ?= soc_harness_top.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "=== PASS ===" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
